// File: channel_bank/channel_bank.sv
// Scope channel bank
`timescale 1ns/1ps
`default_nettype none

module channel_bank (
    input  logic                             clock,
    input  logic                             reset,
    input  scope_channel_pkg::bank_mask_t    in_valid,
    input  scope_channel_pkg::bank_samples_t in_data,
    input  scope_channel_pkg::bank_dests_t   in_dest,
    input  logic                             take,
    output logic                             offer_valid,
    output scope_data_pkg::sample_t          offer_data,
    output scope_data_pkg::dest_t            offer_dest
);

    import scope_data_pkg::*;
    import scope_channel_pkg::*;

    // Latest sample and tag seen on each channel
    sample_t sample_q [bank_channels];
    dest_t   dest_q [bank_channels];

    // Set while a channel holds a sample that has not been taken yet
    bank_mask_t pending;

    // One-hot pointer to the lowest pending channel
    bank_mask_t offer_sel;

    // Flag to drop on this edge, empty unless the combiner takes our offer
    bank_mask_t clear_mask;

    // Isolate the lowest set bit of the pending mask
    assign offer_sel = pending & (~pending + 1'b1);

    assign clear_mask = take ? offer_sel : '0;

    assign offer_valid = |pending;

    // Offer mux driven by the one-hot select
    always_comb begin
        offer_data = '0;
        offer_dest = '0;
        for (int i = 0; i < bank_channels; i++) begin
            if (offer_sel[i]) begin
                offer_data = sample_q[i];
                offer_dest = dest_q[i];
            end
        end
    end

    // A strobe always loads the channel, even if the old sample is still pending,
    // so a source that ignores ready loses its older sample
    always_ff @(posedge clock) begin
        for (int i = 0; i < bank_channels; i++) begin
            if (in_valid[i]) begin
                sample_q[i] <= in_data[i];
                dest_q[i]   <= in_dest[i];
            end
        end
    end

    // Clear first, then set, so a capture on the same edge as a take keeps the flag
    always_ff @(posedge clock) begin
        if (!reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | in_valid;
        end
    end

endmodule

`default_nettype wire

// File: common/scope_channel_pkg.sv
// Scope channel organisation
`default_nettype none

package scope_channel_pkg;

    // Total number of sample channels merged into the output stream
    localparam int n_channels = 6;

    // Channels handled by one bank, two banks cover all channels
    localparam int bank_channels = 3;

    // One bit per channel of a bank, used for strobes and pending flags
    typedef logic [bank_channels-1:0] bank_mask_t;

    // Samples of all channels in one bank, channel 0 of the bank in the low slot
    typedef scope_data_pkg::sample_t [bank_channels-1:0] bank_samples_t;

    // Tags of all channels in one bank
    typedef scope_data_pkg::dest_t [bank_channels-1:0] bank_dests_t;

endpackage

`default_nettype wire

// File: common/scope_data_pkg.sv
// Scope sample data widths
`default_nettype none

package scope_data_pkg;

    // Size of one oscilloscope sample in bits
    localparam int sample_width = 16;

    // Size of the destination tag that travels with each sample
    localparam int dest_width = 8;

    // Size of the packed word on the output stream
    localparam int word_width = 32;

    // One sample in two's complement
    // The vector itself is unsigned, so sign handling is done where the word is packed
    typedef logic [sample_width-1:0] sample_t;

    // Destination tag, passed through unchanged
    typedef logic [dest_width-1:0] dest_t;

    // Output word, holding the sample and optionally the tag in its top byte
    typedef logic [word_width-1:0] word_t;

endpackage

`default_nettype wire

// File: logic/scope_combiner.sv
// Scope stream combiner
`timescale 1ns/1ps
`default_nettype none

module scope_combiner #(
    parameter bit msb_dest_support = 1'b1
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    a_valid,
    input  scope_data_pkg::sample_t a_data,
    input  scope_data_pkg::dest_t   a_dest,
    input  logic                    b_valid,
    input  scope_data_pkg::sample_t b_data,
    input  scope_data_pkg::dest_t   b_dest,
    input  logic                    out_ready,
    output logic                    take_a,
    output logic                    take_b,
    output logic                    out_valid,
    output scope_data_pkg::word_t   out_data,
    output scope_data_pkg::dest_t   out_dest
);

    import scope_data_pkg::*;

    // Registered copy of the sample and tag currently on the output
    sample_t sample_q;
    dest_t   dest_q;

    // Bank A carries the lower channel numbers and always wins
    assign take_a = out_ready && a_valid;
    assign take_b = out_ready && b_valid && !a_valid;

    // The output register only moves while downstream is ready
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= a_valid || b_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (take_a) begin
            sample_q <= a_data;
            dest_q   <= a_dest;
        end else if (take_b) begin
            sample_q <= b_data;
            dest_q   <= b_dest;
        end
    end

    generate
        if (msb_dest_support) begin : g_msb_dest
            // Tag on top, then the sample sign-extended into the gap below it
            assign out_data = {
                dest_q,
                {(word_width - sample_width - dest_width){sample_q[sample_width-1]}},
                sample_q
            };
        end else begin : g_zero_ext
            // Plain sample in the low half, upper bits zero
            assign out_data = {{(word_width - sample_width){1'b0}}, sample_q};
        end
    endgenerate

    // The tag is also given on its own, in both packing modes
    assign out_dest = dest_q;

endmodule

`default_nettype wire

// File: logic/scope_top.sv
// Scope combiner top level
`timescale 1ns/1ps
`default_nettype none

module scope_top #(
    parameter bit msb_dest_support = 1'b1
) (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  logic [scope_channel_pkg::n_channels-1:0]               in_valid,
    input  scope_data_pkg::sample_t [scope_channel_pkg::n_channels-1:0] in_data,
    input  scope_data_pkg::dest_t [scope_channel_pkg::n_channels-1:0]   in_dest,
    output logic                                                   in_ready,
    output logic                                                   out_valid,
    output scope_data_pkg::word_t                                  out_data,
    output scope_data_pkg::dest_t                                  out_dest,
    input  logic                                                   out_ready
);

    import scope_data_pkg::*;
    import scope_channel_pkg::*;

    // Offers from both banks towards the combiner
    logic    a_valid;
    sample_t a_data;
    dest_t   a_dest;
    logic    b_valid;
    sample_t b_data;
    dest_t   b_dest;

    // Take strobes back from the combiner
    logic take_a;
    logic take_b;

    // All channels share the output ready level
    assign in_ready = out_ready;

    // Channels 0 to 2
    channel_bank i_bank_a (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid[bank_channels-1:0]),
        .in_data     (in_data[bank_channels-1:0]),
        .in_dest     (in_dest[bank_channels-1:0]),
        .take        (take_a),
        .offer_valid (a_valid),
        .offer_data  (a_data),
        .offer_dest  (a_dest)
    );

    // Channels 3 to 5
    channel_bank i_bank_b (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid[n_channels-1:bank_channels]),
        .in_data     (in_data[n_channels-1:bank_channels]),
        .in_dest     (in_dest[n_channels-1:bank_channels]),
        .take        (take_b),
        .offer_valid (b_valid),
        .offer_data  (b_data),
        .offer_dest  (b_dest)
    );

    scope_combiner #(
        .msb_dest_support (msb_dest_support)
    ) i_combiner (
        .clock     (clock),
        .reset     (reset),
        .a_valid   (a_valid),
        .a_data    (a_data),
        .a_dest    (a_dest),
        .b_valid   (b_valid),
        .b_data    (b_data),
        .b_dest    (b_dest),
        .out_ready (out_ready),
        .take_a    (take_a),
        .take_b    (take_b),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_dest  (out_dest)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scope combiner simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module scope_tb \
    -f verilog.f \
    -o scope_sim

# The simulator exits non-zero on a failed check, so the log decides the result
./obj_dir/scope_sim | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: verif/scope_assertions.sv
// Scope top level assertions
`timescale 1ns/1ps
`default_nettype none

module scope_assertions (
    input logic                  clock,
    input logic                  reset,
    input logic                  in_ready,
    input logic                  out_valid,
    input scope_data_pkg::word_t out_data,
    input logic                  out_ready
);

    // A reset edge leaves the output register empty
    property reset_clears_valid;
        @(posedge clock) !reset |=> !out_valid;
    endproperty

    // A stalled word may not change or disappear until downstream takes it
    property stalled_word_holds;
        @(posedge clock) disable iff (!reset)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
    endproperty

    // The channels see exactly the downstream ready level
    property ready_passthrough;
        @(posedge clock) in_ready == out_ready;
    endproperty

    assert property (reset_clears_valid)
        else $error("out_valid is high in the cycle after reset");

    assert property (stalled_word_holds)
        else $error("output word changed while out_ready was low");

    assert property (ready_passthrough)
        else $error("in_ready differs from out_ready");

endmodule

bind scope_top scope_assertions i_assertions (
    .clock     (clock),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
);

`default_nettype wire

// File: verif/scope_tb.sv
// Scope combiner testbench
`timescale 1ns/1ps
`default_nettype none

module scope_tb;

    localparam int n_chan = scope_channel_pkg::n_channels;
    localparam int half_period = 2;
    localparam int reset_cycles = 16;
    localparam int word_timeout = 50;
    localparam int idle_timeout = 20;

    logic clock;
    logic reset;
    logic [n_chan-1:0] in_valid;
    scope_data_pkg::sample_t [n_chan-1:0] in_data;
    scope_data_pkg::dest_t [n_chan-1:0] in_dest;
    logic in_ready;
    logic out_valid;
    scope_data_pkg::word_t out_data;
    scope_data_pkg::dest_t out_dest;
    logic out_ready;

    // Values that the next strobe puts on each channel
    scope_data_pkg::sample_t chan_data [n_chan];
    scope_data_pkg::dest_t   chan_dest [n_chan];

    integer seed;
    logic [31:0] rnd;
    int waited;

    scope_top #(
        .msb_dest_support (1'b1)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_ready (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s mismatch, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "check failed");
        end
    endtask

    task automatic draw_random(output logic [31:0] value);
        value = $random(seed);
    endtask

    // Tag in the top byte, then the sign of the sample, then the sample
    function automatic scope_data_pkg::word_t pack_word(input scope_data_pkg::sample_t sample,
                                                        input scope_data_pkg::dest_t dest);
        logic [7:0] ext;
        ext = sample[15] ? 8'hff : 8'h00;
        return {dest, ext, sample};
    endfunction

    task automatic strobe_channels(input logic [n_chan-1:0] mask);
        for (int i = 0; i < n_chan; i++) begin
            in_data[i] = chan_data[i];
            in_dest[i] = chan_dest[i];
        end
        in_valid = mask;
        next_cycle();
        in_valid = '0;
    endtask

    // Outputs are sampled on the falling edge, half a period away from any change
    task automatic wait_for_word(input int chan, output int cycles);
        cycles = 0;
        @(negedge clock);
        while (!(out_valid && out_ready) && cycles < word_timeout) begin
            cycles++;
            @(negedge clock);
        end
        if (!(out_valid && out_ready)) begin
            $display("Timeout: the output word of channel %0d never arrived", chan);
            $display("Finished with errors");
            $fatal(1, "output word timeout");
        end else begin
            check_value(out_data, pack_word(chan_data[chan], chan_dest[chan]), "out_data");
            check_value({24'd0, out_dest}, {24'd0, chan_dest[chan]}, "out_dest");
            check_value({31'd0, in_ready}, 32'd1, "in_ready while ready");
            next_cycle();
        end
    endtask

    task automatic wait_for_idle;
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (out_valid && cycles < idle_timeout) begin
            // Any word still accepted here is one more than was strobed
            if (out_ready) begin
                check_value({31'd0, out_valid}, 32'd0, "out_valid after last word");
            end
            cycles++;
            @(negedge clock);
        end
        if (out_valid) begin
            $display("Timeout: out_valid never fell after the last word");
            $display("Finished with errors");
            $fatal(1, "idle timeout");
        end else begin
            next_cycle();
        end
    endtask

    task automatic idle_after_reset;
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            check_value({31'd0, out_valid}, 32'd0, "out_valid while idle");
        end
        next_cycle();
    endtask

    task automatic single_sample_packing;
        draw_random(rnd);
        chan_data[4] = rnd[15:0] | 16'h8000;
        chan_dest[4] = 8'h5a;
        strobe_channels(6'b010000);
        wait_for_word(4, waited);
        check_value(waited, 32'd1, "cycles before negative sample");
        wait_for_idle();
        chan_data[4] = rnd[31:16] & 16'h7fff;
        strobe_channels(6'b010000);
        wait_for_word(4, waited);
        check_value(waited, 32'd1, "cycles before positive sample");
        wait_for_idle();
    endtask

    task automatic priority_order;
        for (int i = 0; i < n_chan; i++) begin
            draw_random(rnd);
            // Low bits hold the channel number so that all samples differ
            chan_data[i] = {rnd[12:0], 3'(i)};
            chan_dest[i] = rnd[23:16];
        end
        strobe_channels(6'b111111);
        for (int i = 0; i < n_chan; i++) begin
            wait_for_word(i, waited);
        end
        wait_for_idle();
    endtask

    task automatic backpressure_overwrite;
        scope_data_pkg::word_t held;
        draw_random(rnd);
        chan_data[0] = rnd[15:0];
        chan_dest[0] = rnd[23:16];
        held = pack_word(chan_data[0], chan_dest[0]);
        strobe_channels(6'b000001);
        next_cycle();
        out_ready = 1'b0;
        @(negedge clock);
        check_value({31'd0, out_valid}, 32'd1, "out_valid before stall");
        check_value(out_data, held, "out_data before stall");
        next_cycle();
        chan_data[1] = 16'h1111;
        chan_dest[1] = 8'h11;
        chan_data[3] = 16'h3333;
        chan_dest[3] = 8'h33;
        strobe_channels(6'b001010);
        chan_data[1] = 16'hc1c1;
        chan_dest[1] = 8'h21;
        chan_data[3] = 16'h3c3c;
        chan_dest[3] = 8'h23;
        strobe_channels(6'b001010);
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_value({31'd0, out_valid}, 32'd1, "out_valid during stall");
            check_value(out_data, held, "out_data during stall");
            check_value({31'd0, in_ready}, 32'd0, "in_ready during stall");
        end
        next_cycle();
        out_ready = 1'b1;
        wait_for_word(0, waited);
        wait_for_word(1, waited);
        wait_for_word(3, waited);
        wait_for_idle();
    endtask

    task automatic random_bursts;
        logic [n_chan-1:0] mask;
        for (int round = 0; round < 20; round++) begin
            draw_random(rnd);
            mask = rnd[5:0];
            if (mask == '0) begin
                mask = 6'b100000;
            end
            for (int i = 0; i < n_chan; i++) begin
                draw_random(rnd);
                chan_data[i] = rnd[15:0];
                chan_dest[i] = rnd[23:16];
            end
            strobe_channels(mask);
            for (int i = 0; i < n_chan; i++) begin
                if (mask[i]) begin
                    wait_for_word(i, waited);
                end
            end
            wait_for_idle();
        end
    endtask

    initial begin
        seed = 4212;
        reset = 1'b0;
        in_valid = '0;
        in_data = '0;
        in_dest = '0;
        out_ready = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;
        idle_after_reset();
        single_sample_packing();
        priority_order();
        backpressure_overwrite();
        random_bursts();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/scope_data_pkg.sv
common/scope_channel_pkg.sv
channel_bank/channel_bank.sv
logic/scope_combiner.sv
logic/scope_top.sv
verif/scope_assertions.sv
verif/scope_tb.sv
